/* source/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// Register file geometry
`define REG_W      32
`define REG_NUM    32
`define REG_ADDR_W 5

// Instruction word
`define INSTR_W    32

// Fields handed to EXE
`define ALUOP_W    8
`define ALUSEL_W   3

// One bit per exception source
`define EXCP_W     4

`endif

/* source/la_instr_pkg.sv */
`include "id_config.svh"

package la_instr_pkg;

    localparam int OP3R_W    = 17;
    localparam int OP2RI12_W = 10;
    localparam int IMM12_W   = 12;

    // 3R layout, opcode in the top 17 bits
    typedef struct packed {
        logic [OP3R_W-1:0]      opcode;
        logic [`REG_ADDR_W-1:0] rk;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rd;
    } instr_3r_t;

    // 2RI12 layout, 12-bit immediate where 3R keeps rk and the low opcode bits
    typedef struct packed {
        logic [OP2RI12_W-1:0]   opcode;
        logic [IMM12_W-1:0]     si12;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rd;
    } instr_2ri12_t;

    // Same word, seen by both format decoders
    typedef union packed {
        instr_3r_t    r3;
        instr_2ri12_t ri12;
    } instr_word_u;

    // 3R opcodes
    localparam logic [OP3R_W-1:0] OP_ADD_W   = 17'h00020;
    localparam logic [OP3R_W-1:0] OP_SUB_W   = 17'h00022;
    localparam logic [OP3R_W-1:0] OP_SLT     = 17'h00024;
    localparam logic [OP3R_W-1:0] OP_AND     = 17'h00029;
    localparam logic [OP3R_W-1:0] OP_OR      = 17'h0002a;
    localparam logic [OP3R_W-1:0] OP_XOR     = 17'h0002b;
    localparam logic [OP3R_W-1:0] OP_BREAK   = 17'h00054;
    localparam logic [OP3R_W-1:0] OP_SYSCALL = 17'h00056;

    // 2RI12 opcodes
    localparam logic [OP2RI12_W-1:0] OP_SLTI   = 10'h008;
    localparam logic [OP2RI12_W-1:0] OP_ADDI_W = 10'h00a;
    localparam logic [OP2RI12_W-1:0] OP_ANDI   = 10'h00d;
    localparam logic [OP2RI12_W-1:0] OP_ORI    = 10'h00e;
    localparam logic [OP2RI12_W-1:0] OP_XORI   = 10'h00f;

    // ALU operation, zero means no operation
    localparam logic [`ALUOP_W-1:0] ALUOP_ADD = 'd1;
    localparam logic [`ALUOP_W-1:0] ALUOP_SUB = 'd2;
    localparam logic [`ALUOP_W-1:0] ALUOP_SLT = 'd3;
    localparam logic [`ALUOP_W-1:0] ALUOP_AND = 'd4;
    localparam logic [`ALUOP_W-1:0] ALUOP_OR  = 'd5;
    localparam logic [`ALUOP_W-1:0] ALUOP_XOR = 'd6;

    // ALU class
    localparam logic [`ALUSEL_W-1:0] ALUSEL_ARITH = 'd1;
    localparam logic [`ALUSEL_W-1:0] ALUSEL_LOGIC = 'd2;

endpackage

/* source/id_pipe_pkg.sv */
`include "id_config.svh"

package id_pipe_pkg;

    // Entry from the instruction buffer
    typedef struct packed {
        logic                      valid;
        logic [`REG_W-1:0]         pc;
        la_instr_pkg::instr_word_u instr;
        logic                      fetch_excp;
    } instr_buffer_info_t;

    // Format decoder result, all zeros when the format does not match
    typedef struct packed {
        logic                   valid;
        logic [`ALUOP_W-1:0]    aluop;
        logic [`ALUSEL_W-1:0]   alusel;
        // bit 0 is the rj port, bit 1 the rk port
        logic [1:0]             rd_valid;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rk;
        logic                   wr_valid;
        logic [`REG_ADDR_W-1:0] wr_addr;
        logic [`REG_W-1:0]      imm;
        logic                   use_imm;
        logic                   brk;
        logic                   sys;
    } sub_decode_t;

    // Register write, EX forward or WB port
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`REG_W-1:0]      data;
    } fwd_t;

    // ID/EX register contents
    typedef struct packed {
        logic                   valid;
        logic [`REG_W-1:0]      pc;
        logic [`ALUOP_W-1:0]    aluop;
        logic [`ALUSEL_W-1:0]   alusel;
        logic [`REG_W-1:0]      op1;
        logic [`REG_W-1:0]      op2;
        logic                   wr_valid;
        logic [`REG_ADDR_W-1:0] wr_addr;
    } id_ex_t;

    typedef struct packed {
        logic ine;
        logic brk;
        logic sys;
        logic fetch;
    } excp_t;

endpackage

/* source/decoder_3r.sv */
`timescale 1ns/1ps

module decoder_3r (
    input  id_pipe_pkg::instr_buffer_info_t instr_info_i,
    output id_pipe_pkg::sub_decode_t        result_o
);

    import la_instr_pkg::*;

    instr_3r_t word;

    assign word = instr_info_i.instr.r3;

    always_comb begin
        result_o = '0;
        if (instr_info_i.valid) begin
            case (word.opcode)
                OP_ADD_W: begin
                    result_o.aluop  = ALUOP_ADD;
                    result_o.alusel = ALUSEL_ARITH;
                end
                OP_SUB_W: begin
                    result_o.aluop  = ALUOP_SUB;
                    result_o.alusel = ALUSEL_ARITH;
                end
                OP_SLT: begin
                    result_o.aluop  = ALUOP_SLT;
                    result_o.alusel = ALUSEL_ARITH;
                end
                OP_AND: begin
                    result_o.aluop  = ALUOP_AND;
                    result_o.alusel = ALUSEL_LOGIC;
                end
                OP_OR: begin
                    result_o.aluop  = ALUOP_OR;
                    result_o.alusel = ALUSEL_LOGIC;
                end
                OP_XOR: begin
                    result_o.aluop  = ALUOP_XOR;
                    result_o.alusel = ALUSEL_LOGIC;
                end
                // Register fields hold the code here, no register use
                OP_BREAK:   result_o.brk = 1'b1;
                OP_SYSCALL: result_o.sys = 1'b1;
                default:    result_o.aluop = '0;
            endcase
        end

        // ALU ops read rj and rk and write rd
        if (result_o.aluop != '0) begin
            result_o.rd_valid = 2'b11;
            result_o.rj       = word.rj;
            result_o.rk       = word.rk;
            result_o.wr_valid = 1'b1;
            result_o.wr_addr  = word.rd;
        end
        result_o.valid = (result_o.aluop != '0) | result_o.brk | result_o.sys;
    end

endmodule

/* source/decoder_2ri12.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module decoder_2ri12 (
    input  id_pipe_pkg::instr_buffer_info_t instr_info_i,
    output id_pipe_pkg::sub_decode_t        result_o
);

    import la_instr_pkg::*;

    instr_2ri12_t word;
    logic         sign_ext;

    assign word = instr_info_i.instr.ri12;

    always_comb begin
        result_o = '0;
        sign_ext = 1'b0;
        if (instr_info_i.valid) begin
            case (word.opcode)
                OP_SLTI: begin
                    result_o.aluop  = ALUOP_SLT;
                    result_o.alusel = ALUSEL_ARITH;
                    sign_ext        = 1'b1;
                end
                OP_ADDI_W: begin
                    result_o.aluop  = ALUOP_ADD;
                    result_o.alusel = ALUSEL_ARITH;
                    sign_ext        = 1'b1;
                end
                // Logic immediates are zero extended
                OP_ANDI: begin
                    result_o.aluop  = ALUOP_AND;
                    result_o.alusel = ALUSEL_LOGIC;
                end
                OP_ORI: begin
                    result_o.aluop  = ALUOP_OR;
                    result_o.alusel = ALUSEL_LOGIC;
                end
                OP_XORI: begin
                    result_o.aluop  = ALUOP_XOR;
                    result_o.alusel = ALUSEL_LOGIC;
                end
                default: result_o.aluop = '0;
            endcase
        end

        // Only rj is read, the immediate takes the second operand slot
        if (result_o.aluop != '0) begin
            result_o.valid    = 1'b1;
            result_o.rd_valid = 2'b01;
            result_o.rj       = word.rj;
            result_o.wr_valid = 1'b1;
            result_o.wr_addr  = word.rd;
            result_o.use_imm  = 1'b1;
            result_o.imm      = sign_ext ?
                {{(`REG_W-IMM12_W){word.si12[IMM12_W-1]}}, word.si12} :
                {{(`REG_W-IMM12_W){1'b0}}, word.si12};
        end
    end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  id_pipe_pkg::fwd_t      wr_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`REG_W-1:0]      rdata1_o,
    output logic [`REG_W-1:0]      rdata2_o
);

    logic [`REG_W-1:0] regs [`REG_NUM];
    logic              wr_en;

    // r0 stays zero
    assign wr_en = wr_i.valid && (wr_i.addr != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Same-cycle write bypasses the array
    function automatic logic [`REG_W-1:0] read_port(
        input logic [`REG_ADDR_W-1:0] addr
    );
        logic [`REG_W-1:0] value;
        if (wr_en && (wr_i.addr == addr)) begin
            value = wr_i.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

/* source/id_merge.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module id_merge (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  id_pipe_pkg::instr_buffer_info_t instr_info_i,
    input  id_pipe_pkg::sub_decode_t       dec_3r_i,
    input  id_pipe_pkg::sub_decode_t       dec_2ri12_i,
    output logic [`REG_ADDR_W-1:0]         raddr1_o,
    output logic [`REG_ADDR_W-1:0]         raddr2_o,
    input  logic [`REG_W-1:0]              rdata1_i,
    input  logic [`REG_W-1:0]              rdata2_i,
    input  id_pipe_pkg::fwd_t              ex_fwd_i,
    output id_pipe_pkg::id_ex_t            ex_o,
    output id_pipe_pkg::excp_t             excp_o
);

    import id_pipe_pkg::*;

    sub_decode_t       dec;
    logic [`REG_W-1:0] rj_val;
    logic [`REG_W-1:0] rk_val;
    excp_t             excp_d;
    id_ex_t            ex_d;

    // A non-matching decoder drives zeros, so OR is the merge
    assign dec = sub_decode_t'(dec_3r_i | dec_2ri12_i);

    assign raddr1_o = dec.rj;
    assign raddr2_o = dec.rk;

    // Unused port, then r0, then EX forward, then register file
    function automatic logic [`REG_W-1:0] pick_operand(
        input logic                   used,
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`REG_W-1:0]      rf_data,
        input fwd_t                   fwd
    );
        logic [`REG_W-1:0] value;
        if (!used || (addr == '0)) begin
            value = '0;
        end else if (fwd.valid && (fwd.addr == addr)) begin
            value = fwd.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rj_val = pick_operand(dec.rd_valid[0], dec.rj, rdata1_i, ex_fwd_i);
    assign rk_val = pick_operand(dec.rd_valid[1], dec.rk, rdata2_i, ex_fwd_i);

    assign excp_d.ine   = instr_info_i.valid && !dec.valid;
    assign excp_d.brk   = dec.brk;
    assign excp_d.sys   = dec.sys;
    assign excp_d.fetch = instr_info_i.fetch_excp;

    always_comb begin
        ex_d.valid    = instr_info_i.valid;
        ex_d.pc       = instr_info_i.pc;
        ex_d.aluop    = dec.aluop;
        ex_d.alusel   = dec.alusel;
        ex_d.op1      = rj_val;
        ex_d.op2      = dec.use_imm ? dec.imm : rk_val;
        // A faulting instruction must not write back
        ex_d.wr_valid = dec.wr_valid && !(|excp_d);
        ex_d.wr_addr  = dec.wr_addr;
    end

    // ID/EX register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o   <= '0;
            excp_o <= '0;
        end else begin
            ex_o   <= ex_d;
            excp_o <= excp_d;
        end
    end

endmodule

/* source/id_stage_top.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module id_stage_top (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  id_pipe_pkg::instr_buffer_info_t instr_i,
    input  id_pipe_pkg::fwd_t               ex_fwd_i,
    input  id_pipe_pkg::fwd_t               wb_i,
    output id_pipe_pkg::id_ex_t             ex_o,
    output id_pipe_pkg::excp_t              excp_o
);

    import id_pipe_pkg::*;

    sub_decode_t            dec_3r;
    sub_decode_t            dec_2ri12;
    logic [`REG_ADDR_W-1:0] raddr1;
    logic [`REG_ADDR_W-1:0] raddr2;
    logic [`REG_W-1:0]      rdata1;
    logic [`REG_W-1:0]      rdata2;

    // Both format decoders see the same word
    decoder_3r decoder_3r_i (
        .instr_info_i (instr_i),
        .result_o     (dec_3r)
    );

    decoder_2ri12 decoder_2ri12_i (
        .instr_info_i (instr_i),
        .result_o     (dec_2ri12)
    );

    id_merge id_merge_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .instr_info_i (instr_i),
        .dec_3r_i     (dec_3r),
        .dec_2ri12_i  (dec_2ri12),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd_i     (ex_fwd_i),
        .ex_o         (ex_o),
        .excp_o       (excp_o)
    );

    // Write port fed from WB
    regfile regfile_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (wb_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

endmodule

/* verif/id_vectors.svh */
`ifndef ID_VECTORS_SVH
`define ID_VECTORS_SVH

// Columns: instruction, fetch_excp, EX forward (valid, addr, data), WB write (valid, addr, data),
// then expected aluop, alusel, wr_valid, wr_addr, excp {ine, brk, sys, fetch} and use_imm
typedef struct packed {
    logic [`INSTR_W-1:0]    instr;
    logic                   fetch_excp;
    logic                   fwd_valid;
    logic [`REG_ADDR_W-1:0] fwd_addr;
    logic [`REG_W-1:0]      fwd_data;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`REG_W-1:0]      wb_data;
    logic [`ALUOP_W-1:0]    aluop;
    logic [`ALUSEL_W-1:0]   alusel;
    logic                   wr_valid;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`EXCP_W-1:0]     excp;
    logic                   use_imm;
} id_vector_t;

localparam int NUM_VECTORS = 21;

localparam id_vector_t VECTORS [NUM_VECTORS] = '{
    // 3R, fields are {opcode, rk, rj, rd}
    '{{17'h00020, 5'd2, 5'd1, 5'd3}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_ADD, ALUSEL_ARITH, 1'b1, 5'd3, 4'b0000, 1'b0},
    '{{17'h00022, 5'd6, 5'd5, 5'd4}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_SUB, ALUSEL_ARITH, 1'b1, 5'd4, 4'b0000, 1'b0},
    // rk is r0
    '{{17'h00024, 5'd0, 5'd8, 5'd7}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_SLT, ALUSEL_ARITH, 1'b1, 5'd7, 4'b0000, 1'b0},
    // rj is r0
    '{{17'h00029, 5'd10, 5'd0, 5'd9}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_AND, ALUSEL_LOGIC, 1'b1, 5'd9, 4'b0000, 1'b0},
    '{{17'h0002a, 5'd12, 5'd11, 5'd10}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_OR, ALUSEL_LOGIC, 1'b1, 5'd10, 4'b0000, 1'b0},
    '{{17'h0002b, 5'd14, 5'd13, 5'd11}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_XOR, ALUSEL_LOGIC, 1'b1, 5'd11, 4'b0000, 1'b0},
    // 2RI12, fields are {opcode, si12, rj, rd}
    '{{10'h00a, 12'h7ff, 5'd1, 5'd12}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_ADD, ALUSEL_ARITH, 1'b1, 5'd12, 4'b0000, 1'b1},
    '{{10'h00a, 12'h800, 5'd2, 5'd13}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_ADD, ALUSEL_ARITH, 1'b1, 5'd13, 4'b0000, 1'b1},
    '{{10'h008, 12'hfff, 5'd3, 5'd14}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_SLT, ALUSEL_ARITH, 1'b1, 5'd14, 4'b0000, 1'b1},
    '{{10'h00d, 12'hf0f, 5'd4, 5'd15}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_AND, ALUSEL_LOGIC, 1'b1, 5'd15, 4'b0000, 1'b1},
    '{{10'h00e, 12'h800, 5'd5, 5'd16}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_OR, ALUSEL_LOGIC, 1'b1, 5'd16, 4'b0000, 1'b1},
    '{{10'h00f, 12'habc, 5'd6, 5'd17}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_XOR, ALUSEL_LOGIC, 1'b1, 5'd17, 4'b0000, 1'b1},
    // EX forward on rj, then on rk
    '{{17'h00020, 5'd2, 5'd1, 5'd18}, 1'b0, 1'b1, 5'd1, 32'hdeadbeef, 1'b0, 5'd0, 32'h0,
      ALUOP_ADD, ALUSEL_ARITH, 1'b1, 5'd18, 4'b0000, 1'b0},
    '{{17'h00022, 5'd2, 5'd3, 5'd19}, 1'b0, 1'b1, 5'd2, 32'h12345678, 1'b0, 5'd0, 32'h0,
      ALUOP_SUB, ALUSEL_ARITH, 1'b1, 5'd19, 4'b0000, 1'b0},
    // WB writes r8 in the same cycle it is read
    '{{17'h00020, 5'd8, 5'd7, 5'd20}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b1, 5'd8, 32'hcafef00d,
      ALUOP_ADD, ALUSEL_ARITH, 1'b1, 5'd20, 4'b0000, 1'b0},
    // EX forward beats a WB write to the same register
    '{{10'h00a, 12'h005, 5'd9, 5'd21}, 1'b0, 1'b1, 5'd9, 32'h11110000, 1'b1, 5'd9, 32'h22220000,
      ALUOP_ADD, ALUSEL_ARITH, 1'b1, 5'd21, 4'b0000, 1'b1},
    // Forwarding r0 must not change it
    '{{10'h00e, 12'h0ff, 5'd0, 5'd22}, 1'b0, 1'b1, 5'd0, 32'hffffffff, 1'b0, 5'd0, 32'h0,
      ALUOP_OR, ALUSEL_LOGIC, 1'b1, 5'd22, 4'b0000, 1'b1},
    // Unknown opcode, break, syscall
    '{{17'h1ffff, 15'h0}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      8'd0, 3'd0, 1'b0, 5'd0, 4'b1000, 1'b0},
    '{{17'h00054, 15'h0}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      8'd0, 3'd0, 1'b0, 5'd0, 4'b0100, 1'b0},
    '{{17'h00056, 15'h0}, 1'b0, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      8'd0, 3'd0, 1'b0, 5'd0, 4'b0010, 1'b0},
    // Fetch fault on a valid add.w
    '{{17'h00020, 5'd2, 5'd1, 5'd23}, 1'b1, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0,
      ALUOP_ADD, ALUSEL_ARITH, 1'b0, 5'd23, 4'b0001, 1'b0}
};

`endif

/* verif/tb_id_stage.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module tb_id_stage;

    import id_pipe_pkg::*;
    import la_instr_pkg::*;

    `include "id_vectors.svh"

    localparam int RESET_CYCLES   = 8;
    localparam int PRELOAD_REGS   = 15;
    // Register writes plus the idle cycles around them
    localparam int PRELOAD_CYCLES = PRELOAD_REGS + 3;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + PRELOAD_CYCLES + NUM_VECTORS * 2 + 20;
    localparam logic [`REG_W-1:0] PC_BASE = 32'h1c00_0000;

    logic               clk = 1'b0;
    logic               arst_n_i;
    instr_buffer_info_t instr_i;
    fwd_t               ex_fwd_i;
    fwd_t               wb_i;
    id_ex_t             ex_o;
    excp_t              excp_o;

    // Expected register file contents
    logic [`REG_W-1:0]  model_regs [`REG_NUM];
    logic [`REG_W-1:0]  exp_pc;
    logic [`REG_W-1:0]  exp_op1;
    logic [`REG_W-1:0]  exp_op2;
    int                 seed;
    int                 error_count = 0;
    int                 cycle_count = 0;

    always #5 clk = ~clk;

    id_stage_top id_stage_top_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .instr_i  (instr_i),
        .ex_fwd_i (ex_fwd_i),
        .wb_i     (wb_i),
        .ex_o     (ex_o),
        .excp_o   (excp_o)
    );

    task automatic report_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_run();
        $display("Simulation done with %0d errors", error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // ID/EX valid, write enable and all exception bits low
    task automatic check_cleared(input string when);
        if (ex_o.valid !== 1'b0 || ex_o.wr_valid !== 1'b0 || excp_o !== '0)
            report_mismatch($sformatf("%s valid %b wr_valid %b excp %b, expected all zero",
                                      when, ex_o.valid, ex_o.wr_valid, excp_o));
    endtask

    // r0, then EX forward, then the register model
    function automatic logic [`REG_W-1:0] operand_value(
        input logic [`REG_ADDR_W-1:0] addr,
        input id_vector_t             v
    );
        logic [`REG_W-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (v.fwd_valid && (v.fwd_addr == addr)) begin
            value = v.fwd_data;
        end else begin
            value = model_regs[addr];
        end
        return value;
    endfunction

    task automatic drive_row(input int idx);
        id_vector_t             v;
        logic [`REG_ADDR_W-1:0] rj;
        logic [`REG_ADDR_W-1:0] rk;
        logic [11:0]            si12;
        v    = VECTORS[idx];
        rj   = v.instr[9:5];
        rk   = v.instr[14:10];
        si12 = v.instr[21:10];

        instr_i.valid      = 1'b1;
        instr_i.pc         = PC_BASE + idx * 4;
        instr_i.instr      = v.instr;
        instr_i.fetch_excp = v.fetch_excp;
        ex_fwd_i.valid     = v.fwd_valid;
        ex_fwd_i.addr      = v.fwd_addr;
        ex_fwd_i.data      = v.fwd_data;
        wb_i.valid         = v.wb_valid;
        wb_i.addr          = v.wb_addr;
        wb_i.data          = v.wb_data;

        // A same-cycle write is already visible to this read
        if (v.wb_valid && (v.wb_addr != '0)) begin
            model_regs[v.wb_addr] = v.wb_data;
        end

        exp_pc = instr_i.pc;
        if (v.aluop == '0) begin
            // No ALU op, so nothing is read
            exp_op1 = '0;
            exp_op2 = '0;
        end else begin
            exp_op1 = operand_value(rj, v);
            if (!v.use_imm) begin
                exp_op2 = operand_value(rk, v);
            end else if (v.alusel == ALUSEL_ARITH) begin
                // addi.w and slti
                exp_op2 = {{20{si12[11]}}, si12};
            end else begin
                exp_op2 = {20'h0, si12};
            end
        end
    endtask

    task automatic check_row(input int idx);
        id_vector_t v;
        string      tag;
        v   = VECTORS[idx];
        tag = $sformatf("row %0d", idx);
        if (ex_o.valid !== 1'b1)
            report_mismatch($sformatf("%s valid is %b, expected 1", tag, ex_o.valid));
        if (ex_o.pc !== exp_pc)
            report_mismatch($sformatf("%s pc is %h, expected %h", tag, ex_o.pc, exp_pc));
        if (ex_o.aluop !== v.aluop)
            report_mismatch($sformatf("%s aluop is %h, expected %h", tag, ex_o.aluop, v.aluop));
        if (ex_o.alusel !== v.alusel)
            report_mismatch($sformatf("%s alusel is %h, expected %h", tag, ex_o.alusel, v.alusel));
        if (ex_o.op1 !== exp_op1)
            report_mismatch($sformatf("%s op1 is %h, expected %h", tag, ex_o.op1, exp_op1));
        if (ex_o.op2 !== exp_op2)
            report_mismatch($sformatf("%s op2 is %h, expected %h", tag, ex_o.op2, exp_op2));
        if (ex_o.wr_valid !== v.wr_valid)
            report_mismatch($sformatf("%s wr_valid is %b, expected %b", tag, ex_o.wr_valid,
                                      v.wr_valid));
        if (ex_o.wr_addr !== v.wr_addr)
            report_mismatch($sformatf("%s wr_addr is %0d, expected %0d", tag, ex_o.wr_addr,
                                      v.wr_addr));
        if (excp_o !== v.excp)
            report_mismatch($sformatf("%s excp is %b, expected %b", tag, excp_o, v.excp));
    endtask

    initial begin
        seed     = 40;
        arst_n_i = 1'b0;
        instr_i  = '0;
        ex_fwd_i = '0;
        wb_i     = '0;
        for (int r = 0; r < `REG_NUM; r++) begin
            model_regs[r] = '0;
        end

        // Live instructions at the input while reset holds ID/EX clear
        instr_i.valid = 1'b1;
        instr_i.pc    = PC_BASE;
        instr_i.instr = VECTORS[0].instr;
        repeat (RESET_CYCLES / 2) @(posedge clk);
        @(negedge clk);
        check_cleared("in reset with add.w");
        // Unknown opcode with a fetch fault
        instr_i = '1;
        repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clk);
        @(negedge clk);
        check_cleared("in reset with a faulting word");
        instr_i  = '0;
        arst_n_i = 1'b1;

        // Nothing issued yet
        @(negedge clk);
        check_cleared("idle");

        // Random contents for r1 to r15 through the WB port
        for (int r = 1; r <= PRELOAD_REGS; r++) begin
            @(negedge clk);
            wb_i.valid    = 1'b1;
            wb_i.addr     = r[`REG_ADDR_W-1:0];
            wb_i.data     = $random(seed);
            model_regs[r] = wb_i.data;
        end
        @(negedge clk);
        wb_i = '0;

        // Back to back, each row is checked while the next one is driven
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_row(i - 1);
            end
            drive_row(i);
        end
        @(negedge clk);
        check_row(NUM_VECTORS - 1);
        instr_i  = '0;
        ex_fwd_i = '0;
        wb_i     = '0;
        finish_run();
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
            error_count++;
            finish_run();
        end
    end

endmodule

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_id_stage
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+source
+incdir+verif
source/la_instr_pkg.sv
source/id_pipe_pkg.sv
source/decoder_3r.sv
source/decoder_2ri12.sv
source/regfile.sv
source/id_merge.sv
source/id_stage_top.sv
verif/tb_id_stage.sv
